// File: sources.f
+incdir+rtl
rtl/autocat_pkg.sv
rtl/access_handshake.sv
rtl/hit_counter_array.sv
rtl/bitonic_sorter.sv
rtl/waymask_selector.sv
rtl/autocat.sv
verif/autocat_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module autocat_tb -o autocat_sim

./obj_dir/autocat_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "Test completed successfully" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

// File: verif/autocat_tb.sv
`timescale 1ns/1ps
`include "autocat_config.svh"

module autocat_tb;

    localparam int num_epochs     = 5;
    localparam int epoch_accesses = 1 << `AUTOCAT_EPOCH_POWER;
    localparam int phase_limit    = 50; // cycles allowed for one handshake phase
    localparam int hold_cycles    = 24;
    // capture edge, snapshot edge, ten sorter layers and the selector register
    localparam int update_latency = 12;
    localparam longint watchdog_ns = longint'(num_epochs) * epoch_accesses * 8 * 10 + 20000;

    logic                  clk_in;
    logic                  reset_with_request_limit;
    logic                  access_req;
    autocat_pkg::way_vec_t hit_vec;
    logic                  access_ack;
    autocat_pkg::way_vec_t suggested_waymask;
    logic                  waymask_update;

    logic [15:0]           lfsr_state;
    int                    model_counts [`AUTOCAT_WAYS];
    autocat_pkg::way_vec_t expected_masks [$];
    autocat_pkg::way_vec_t mask_bounds [$];
    int                    epoch_ack_cycles [$];
    int                    cycle_count = 0;
    int                    updates_seen = 0;

    autocat autocat_i
    (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .access_req               (access_req),
        .hit_vec                  (hit_vec),
        .access_ack               (access_ack),
        .suggested_waymask        (suggested_waymask),
        .waymask_update           (waymask_update)
    );

    initial
        clk_in = 1'b0;

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in)
        cycle_count <= cycle_count + 1;

    // ========================================
    // random source and checks
    // ========================================

    // taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic random_bits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_waymask(input string name, input autocat_pkg::way_vec_t actual,
                                 input autocat_pkg::way_vec_t expected);
        if (actual !== expected)
        begin
            $display("FAILED %s: actual %h expected %h", name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_ack(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("FAILED %s: actual %h expected %h", name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_latency(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("FAILED %s: actual %h expected %h", name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // ========================================
    // reference model
    // ========================================

    task automatic model_clear();
        for (int k = 0; k < `AUTOCAT_WAYS; k++)
            model_counts[k] = 0;
    endtask

    // a hit at position p would also hit in every partition wider than p
    task automatic model_record(input int position);
        for (int k = 0; k < `AUTOCAT_WAYS; k++)
        begin
            if (position >= 0 && k >= position)
                model_counts[k]++;
        end
    endtask

    function automatic autocat_pkg::way_vec_t predict_mask();
        int                    scaled [`AUTOCAT_WAYS];
        int                    best;
        int                    chosen;
        autocat_pkg::way_vec_t mask;
        best = 0;
        for (int k = 0; k < `AUTOCAT_WAYS; k++)
        begin
            scaled[k] = model_counts[k] * 16 / epoch_accesses; // sixteenths of an epoch
            if (scaled[k] > best)
                best = scaled[k];
        end
        chosen = `AUTOCAT_WAYS - 1;
        for (int k = `AUTOCAT_WAYS - 1; k >= 0; k--)
        begin
            if (scaled[k] + `AUTOCAT_ALLOWED_GAP >= best)
                chosen = k;
        end
        mask = '0;
        for (int k = 0; k <= chosen; k++)
            mask[k] = 1'b1;
        return mask;
    endfunction

    // ========================================
    // handshake driver
    // ========================================

    task automatic perform_access(input int position, input int hold, output int ack_cycle);
        int waited;
        hit_vec    = (position < 0) ? '0 : autocat_pkg::way_vec_t'(1 << position);
        access_req = 1'b1;
        waited     = 0;
        @(posedge clk_in);
        #1;
        while (!access_ack)
        begin
            waited++;
            if (waited > phase_limit)
                stop_with_error("access_ack did not rise after access_req was raised");
            @(posedge clk_in);
            #1;
        end
        check_latency("access_ack rise delay", waited, 0); // first edge that sees req high
        ack_cycle = cycle_count;
        for (int h = 0; h < hold; h++)
        begin
            hit_vec = ~hit_vec; // changes after acceptance must not be counted
            @(posedge clk_in);
            #1;
            check_ack("access_ack", access_ack, 1'b1);
        end
        access_req = 1'b0;
        waited     = 0;
        @(posedge clk_in);
        #1;
        while (access_ack)
        begin
            waited++;
            if (waited > phase_limit)
                stop_with_error("access_ack did not fall after access_req was dropped");
            @(posedge clk_in);
            #1;
        end
        check_latency("access_ack fall delay", waited, 0); // first edge that sees req low
    endtask

    task automatic idle_gap(input int cycles);
        for (int c = 0; c < cycles; c++)
        begin
            @(posedge clk_in);
            #1;
            check_ack("access_ack", access_ack, 1'b0);
        end
    endtask

    // kind 0 is a random profile skewed by bias, kind 1 hits only positions 0 and 1,
    // any other kind is all misses
    task automatic run_epoch(input int kind, input int bias, input bit holds);
        int position;
        int draw;
        int gap;
        int ack_cycle;
        model_clear();
        for (int n = 0; n < epoch_accesses; n++)
        begin
            position = -1;
            if (kind == 0)
            begin
                random_bits(2, draw);
                if (draw != 0)
                begin
                    random_bits(4, draw);
                    position = draw >> bias;
                end
            end
            else if (kind == 1)
            begin
                random_bits(1, draw);
                position = draw;
            end
            random_bits(2, gap);
            perform_access(position, (holds && (n % 64 == 5)) ? hold_cycles : 0, ack_cycle);
            model_record(position);
            if (n == epoch_accesses - 1)
            begin
                expected_masks.push_back(predict_mask());
                epoch_ack_cycles.push_back(ack_cycle);
                if (kind == 0)
                    mask_bounds.push_back('1);
                else if (kind == 1)
                    mask_bounds.push_back(autocat_pkg::way_vec_t'(3));
                else
                    mask_bounds.push_back(autocat_pkg::way_vec_t'(1));
            end
            idle_gap(gap);
        end
    endtask

    task automatic wait_for_updates();
        int waited;
        waited = 0;
        while (updates_seen < num_epochs && waited < 4 * update_latency)
        begin
            @(posedge clk_in);
            waited++;
        end
    endtask

    // ========================================
    // mask monitor
    // ========================================

    always @(negedge clk_in)
    begin
        if (!reset_with_request_limit && waymask_update)
        begin
            if (expected_masks.size() == 0)
                stop_with_error("waymask_update pulsed although no epoch had completed");
            else
            begin
                check_latency("waymask_update latency",
                              cycle_count - epoch_ack_cycles.pop_front(), update_latency);
                check_waymask("suggested_waymask", suggested_waymask,
                              expected_masks.pop_front());
                check_waymask("suggested_waymask outside profile",
                              suggested_waymask & ~mask_bounds.pop_front(), '0);
                updates_seen++;
            end
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("simulation ran past its time limit");
        $display("Test failed");
        $fatal(1);
    end

    initial
    begin
        lfsr_state               = 16'd79;
        access_req               = 1'b0;
        hit_vec                  = '0;
        reset_with_request_limit = 1'b1;
        repeat (16) @(posedge clk_in);
        #1;
        reset_with_request_limit = 1'b0;
        check_waymask("suggested_waymask", suggested_waymask, '1);
        check_ack("access_ack", access_ack, 1'b0);

        run_epoch(0, 2, 1'b0); // hits mostly in the first four positions
        run_epoch(1, 0, 1'b0);
        run_epoch(2, 0, 1'b0);
        run_epoch(0, 0, 1'b0);
        run_epoch(0, 1, 1'b1); // long holds on access_req
        wait_for_updates();

        if (updates_seen == num_epochs)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
            stop_with_error($sformatf("expected %0d mask updates but saw %0d",
                                      num_epochs, updates_seen));
    end

endmodule

// File: rtl/autocat.sv
`timescale 1ns/1ps

module autocat
(
    input  logic                   clk_in,
    input  logic                   reset_with_request_limit,
    input  logic                   access_req,
    input  autocat_pkg::way_vec_t  hit_vec,
    output logic                   access_ack,
    output autocat_pkg::way_vec_t  suggested_waymask,
    output logic                   waymask_update
);

    autocat_pkg::way_vec_t        captured_hit_vec;
    logic                         count_strobe;
    logic                         epoch_end;
    autocat_pkg::counter_array_t  snapshot;
    logic                         snapshot_valid;
    autocat_pkg::counter_array_t  sorted;
    logic                         sorted_valid;

    // ========================================
    // access intake
    // ========================================

    access_handshake access_handshake_i
    (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .access_req               (access_req),
        .hit_vec                  (hit_vec),
        .access_ack               (access_ack),
        .captured_hit_vec         (captured_hit_vec),
        .count_strobe             (count_strobe),
        .epoch_end                (epoch_end)
    );

    hit_counter_array hit_counter_array_i
    (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .count_strobe             (count_strobe),
        .captured_hit_vec         (captured_hit_vec),
        .epoch_end                (epoch_end),
        .snapshot                 (snapshot),
        .snapshot_valid           (snapshot_valid)
    );

    // ========================================
    // per-epoch decision
    // ========================================

    bitonic_sorter bitonic_sorter_i
    (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .snapshot                 (snapshot),
        .snapshot_valid           (snapshot_valid),
        .sorted                   (sorted),
        .sorted_valid             (sorted_valid)
    );

    waymask_selector waymask_selector_i
    (
        .clk_in                   (clk_in),
        .reset_with_request_limit (reset_with_request_limit),
        .sorted                   (sorted),
        .sorted_valid             (sorted_valid),
        .suggested_waymask        (suggested_waymask),
        .waymask_update           (waymask_update)
    );

endmodule

// File: rtl/waymask_selector.sv
`timescale 1ns/1ps
`include "autocat_config.svh"

module waymask_selector
(
    input  logic                         clk_in,
    input  logic                         reset_with_request_limit,
    input  autocat_pkg::counter_array_t  sorted,
    input  logic                         sorted_valid,
    output autocat_pkg::way_vec_t        suggested_waymask,
    output logic                         waymask_update
);

    localparam int scale_shift = `AUTOCAT_EPOCH_POWER - 4; // counts become sixteenths of an epoch

    autocat_pkg::counter_t         scaled [`AUTOCAT_WAYS];
    logic [$clog2(`AUTOCAT_WAYS)-1:0] best_index;
    autocat_pkg::way_vec_t         next_mask;

    // ========================================
    // smallest sufficient partition
    // ========================================

    always_comb
    begin
        for (int i = 0; i < `AUTOCAT_WAYS; i++)
            scaled[i] = sorted[i] >> scale_shift;

        best_index = '1;
        for (int i = `AUTOCAT_WAYS - 1; i >= 0; i--)
        begin
            // scanning downward leaves the smallest qualifying index
            if (scaled[i] + autocat_pkg::counter_t'(`AUTOCAT_ALLOWED_GAP) >=
                scaled[`AUTOCAT_WAYS - 1])
                best_index = i[$clog2(`AUTOCAT_WAYS)-1:0];
        end

        for (int i = 0; i < `AUTOCAT_WAYS; i++)
            next_mask[i] = (i <= int'(best_index)); // contiguous from way 0
    end

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            suggested_waymask <= '1; // all ways until the first epoch completes
            waymask_update    <= 1'b0;
        end
        else
        begin
            waymask_update <= sorted_valid;
            if (sorted_valid)
                suggested_waymask <= next_mask;
        end
    end

    mask_contiguous: assert property (@(posedge clk_in) disable iff (reset_with_request_limit)
        suggested_waymask[0] &&
        ((suggested_waymask & autocat_pkg::way_vec_t'(suggested_waymask + 1'b1)) == '0))
        else $error("way mask %h is not contiguous from way 0", suggested_waymask);

endmodule

// File: rtl/bitonic_sorter.sv
`timescale 1ns/1ps
`include "autocat_config.svh"

module bitonic_sorter
(
    input  logic                         clk_in,
    input  logic                         reset_with_request_limit,
    input  autocat_pkg::counter_array_t  snapshot,
    input  logic                         snapshot_valid,
    output autocat_pkg::counter_array_t  sorted,
    output logic                         sorted_valid
);

    localparam int levels = $clog2(`AUTOCAT_WAYS);
    localparam int layers = levels * (levels + 1) / 2; // 10 for 16 inputs

    autocat_pkg::counter_array_t stage_data [layers];
    logic [layers-1:0]           valid_pipe;

    // leaves data[lo] holding the smaller of the pair
    function automatic autocat_pkg::counter_array_t compare_exchange(
        input autocat_pkg::counter_array_t data,
        input int                          lo,
        input int                          hi
    );
        autocat_pkg::counter_array_t result;
        result = data;
        if (data[lo] > data[hi])
        begin
            result[lo] = data[hi];
            result[hi] = data[lo];
        end
        return result;
    endfunction

    function automatic autocat_pkg::counter_array_t exchange_layer(
        input autocat_pkg::counter_array_t data,
        input int                          block,
        input int                          distance
    );
        autocat_pkg::counter_array_t result;
        int                          partner;
        result = data;
        for (int i = 0; i < `AUTOCAT_WAYS; i++)
        begin
            partner = i ^ distance;
            if (partner > i)
            begin
                if ((i & block) == 0)
                    result = compare_exchange(result, i, partner); // ascending half
                else
                    result = compare_exchange(result, partner, i); // descending half
            end
        end
        return result;
    endfunction

    // ========================================
    // compare-exchange layers
    // ========================================

    for (genvar s = 1; s <= levels; s++)
    begin : g_merge
        for (genvar u = 0; u < s; u++)
        begin : g_layer
            localparam int layer    = s * (s - 1) / 2 + u;
            localparam int block    = 1 << s;
            localparam int distance = 1 << (s - 1 - u);

            autocat_pkg::counter_array_t layer_in;

            if (layer == 0)
            begin : g_first
                assign layer_in = snapshot;
            end
            else
            begin : g_next
                assign layer_in = stage_data[layer - 1];
            end

            always_ff @(posedge clk_in)
            begin
                stage_data[layer] <= exchange_layer(layer_in, block, distance);
            end
        end
    end

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[layers-2:0], snapshot_valid}; // travels with the data
    end

    assign sorted       = stage_data[layers - 1];
    assign sorted_valid = valid_pipe[layers - 1];

    function automatic logic is_nondecreasing(input autocat_pkg::counter_array_t data);
        logic ordered;
        ordered = 1'b1;
        for (int i = 0; i < `AUTOCAT_WAYS - 1; i++)
            ordered &= (data[i] <= data[i + 1]);
        return ordered;
    endfunction

    sorted_order: assert property (@(posedge clk_in) disable iff (reset_with_request_limit)
        sorted_valid |-> is_nondecreasing(sorted))
        else $error("sorter output is not in ascending order");

endmodule

// File: rtl/hit_counter_array.sv
`timescale 1ns/1ps
`include "autocat_config.svh"

module hit_counter_array
(
    input  logic                         clk_in,
    input  logic                         reset_with_request_limit,
    input  logic                         count_strobe,
    input  autocat_pkg::way_vec_t        captured_hit_vec,
    input  logic                         epoch_end,
    output autocat_pkg::counter_array_t  snapshot,
    output logic                         snapshot_valid
);

    autocat_pkg::way_vec_t         hit_within;  // bit k set when the hit lies in ways 0 to k
    autocat_pkg::counter_array_t   counts;
    autocat_pkg::counter_array_t   counts_next;

    always_comb
    begin
        hit_within[0] = captured_hit_vec[0];
        for (int k = 1; k < `AUTOCAT_WAYS; k++)
            hit_within[k] = hit_within[k - 1] | captured_hit_vec[k]; // prefix OR over positions
        for (int k = 0; k < `AUTOCAT_WAYS; k++)
            counts_next[k] = counts[k] + autocat_pkg::counter_t'(hit_within[k]);
    end

    // ========================================
    // live counters
    // ========================================

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            counts         <= '0;
            snapshot_valid <= 1'b0;
        end
        else
        begin
            snapshot_valid <= count_strobe && epoch_end;
            if (count_strobe)
                counts <= epoch_end ? '0 : counts_next; // synchronous epoch restart
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (count_strobe && epoch_end)
            snapshot <= counts_next; // includes the last access of the epoch
    end

    // larger partitions can never see fewer hits
    for (genvar k = 0; k < `AUTOCAT_WAYS - 1; k++)
    begin : g_monotonic
        snapshot_monotonic: assert property (@(posedge clk_in)
            disable iff (reset_with_request_limit)
            snapshot_valid |-> snapshot[k + 1] >= snapshot[k])
            else $error("snapshot counter %0d exceeds counter %0d", k, k + 1);
    end

endmodule

// File: rtl/access_handshake.sv
`timescale 1ns/1ps
`include "autocat_config.svh"

module access_handshake
(
    input  logic                   clk_in,
    input  logic                   reset_with_request_limit,
    input  logic                   access_req,
    input  autocat_pkg::way_vec_t  hit_vec,
    output logic                   access_ack,
    output autocat_pkg::way_vec_t  captured_hit_vec,
    output logic                   count_strobe,
    output logic                   epoch_end
);

    localparam autocat_pkg::epoch_count_t epoch_length =
        autocat_pkg::epoch_count_t'(1 << `AUTOCAT_EPOCH_POWER);

    autocat_pkg::epoch_count_t access_count;
    autocat_pkg::epoch_count_t access_count_next;
    logic                      accept;

    assign accept            = access_req && !access_ack; // new request not yet acknowledged
    assign access_count_next = access_count + 1'b1;

    // ========================================
    // four-phase receiver
    // ========================================

    always_ff @(posedge clk_in or posedge reset_with_request_limit)
    begin
        if (reset_with_request_limit)
        begin
            access_ack   <= 1'b0;
            count_strobe <= 1'b0;
            epoch_end    <= 1'b0;
            access_count <= '0;
        end
        else
        begin
            access_ack   <= access_req; // ack follows req in both directions
            count_strobe <= accept;
            epoch_end    <= accept && (access_count_next == epoch_length);
            if (accept)
            begin
                if (access_count_next == epoch_length)
                    access_count <= '0; // wrap on the last access of the epoch
                else
                    access_count <= access_count_next;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
            captured_hit_vec <= hit_vec;
    end

    // ========================================
    // protocol checks
    // ========================================

    ack_needs_req: assert property (@(posedge clk_in) disable iff (reset_with_request_limit)
        $rose(access_ack) |-> $past(access_req))
        else $error("access_ack rose without access_req");

    hit_vec_stable: assert property (@(posedge clk_in) disable iff (reset_with_request_limit)
        access_req && !access_ack && $past(access_req) |-> $stable(hit_vec))
        else $error("hit_vec changed before access_ack rose");

endmodule

// File: rtl/autocat_pkg.sv
`include "autocat_config.svh"

package autocat_pkg;

    // ========================================
    // shared types
    // ========================================

    // one bit per way, used for hit positions and masks
    typedef logic [`AUTOCAT_WAYS-1:0] way_vec_t;

    typedef logic [`AUTOCAT_COUNTER_WIDTH-1:0] counter_t;

    // element k holds the hits for a partition of k+1 ways
    typedef counter_t [`AUTOCAT_WAYS-1:0] counter_array_t;

    // one extra bit so the count can reach the full epoch length
    typedef logic [`AUTOCAT_EPOCH_POWER:0] epoch_count_t;

endpackage

// File: rtl/autocat_config.svh
`ifndef AUTOCAT_CONFIG_SVH
`define AUTOCAT_CONFIG_SVH

// ========================================
// cache geometry
// ========================================

`define AUTOCAT_WAYS 16 // the sorter network is built for exactly this many inputs

// ========================================
// counting and decision
// ========================================

`define AUTOCAT_COUNTER_WIDTH 32

// one epoch is 2**AUTOCAT_EPOCH_POWER accepted accesses
`define AUTOCAT_EPOCH_POWER 10

// tolerated shortfall in sixteenths of an epoch
`define AUTOCAT_ALLOWED_GAP 1

`endif
